//--- compile.f
src/sdCmdPkg.sv
src/crc7Serial.sv
src/cmdRequestDecoder.sv
src/cmdLineSender.sv
src/respReceiver.sv
src/sdCmdController.sv
dv/tbSdCmd.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tbSdCmd \
    -f compile.f -o simSdCmd &&
./obj_dir/simSdCmd | tee /dev/stderr | grep -q "^test passed$" &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }

//--- dv/tbSdCmd.sv
`timescale 1ns/1ns
`default_nettype none

module tbSdCmd;

    localparam int TurnaroundCycles = 3;
    localparam int NumCommands = 40;
    // Long response plus the longest card delay and idle gap fit well within this
    localparam int TimeoutCycles = NumCommands * 300;

    logic clk_fast;
    logic reset;
    logic cmdTrigger;
    sdCmdPkg::cmdFrame_t cmdData;
    sdCmdPkg::respType_e cmdRespType;
    logic cmdIn;
    wire cmdOut;
    wire cmdOutEn;
    wire cmdDone;
    wire respDone;
    wire sdCmdPkg::respFrame_t respData;
    wire respCrcErr;

    int cycleCount = 0;
    logic expCmdDone;
    logic expRespDone;

    sdCmdController #(
        .TurnaroundCycles(TurnaroundCycles)
    ) i_sdCmdController (
        .clk_fast(clk_fast),
        .reset(reset),
        .cmdTrigger(cmdTrigger),
        .cmdData(cmdData),
        .cmdRespType(cmdRespType),
        .cmdIn(cmdIn),
        .cmdOut(cmdOut),
        .cmdOutEn(cmdOutEn),
        .cmdDone(cmdDone),
        .respDone(respDone),
        .respData(respData),
        .respCrcErr(respCrcErr)
    );

    initial clk_fast = 1'b0;
    always #5 clk_fast = ~clk_fast;

    always @(posedge clk_fast) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("test failed");
            $fatal(1, "Watchdog expired");
        end
    end

    // ==========================================================
    // Reference model
    // ==========================================================

    // CRC7 of bits msb down to lsb, x^7 + x^3 + 1, MSB first
    function automatic sdCmdPkg::crc7_t crc7Of(input sdCmdPkg::respFrame_t bits,
                                               input int msb, input int lsb);
        sdCmdPkg::crc7_t rem;
        logic top;
        rem = '0;
        for (int i = msb; i >= lsb; i--) begin
            top = rem[6] ^ bits[i];
            rem = {rem[5:0], 1'b0};
            if (top) begin
                rem = rem ^ 7'h09;
            end
        end
        return rem;
    endfunction

    task automatic compareValue(input logic [135:0] actual, input logic [135:0] expected,
                                input string what);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // ==========================================================
    // Host side and card model
    // ==========================================================

    // Released CMD line goes back to 1 with every trigger, which also ends an aborted response
    task automatic issueCommand(input sdCmdPkg::cmdFrame_t data,
                                input sdCmdPkg::respType_e kind);
        @(posedge clk_fast);
        cmdData <= data;
        cmdRespType <= kind;
        cmdTrigger <= !cmdTrigger;
        cmdIn <= 1'b1;
    endtask

    // Rebuild the frame from the line, then check cmdDone timing
    task automatic checkCommandFrame(input sdCmdPkg::cmdFrame_t data);
        sdCmdPkg::cmdFrame_t frame;
        int width;
        frame = '0;
        width = 0;
        @(negedge clk_fast);
        while (!cmdOutEn) begin
            @(negedge clk_fast);
        end
        while (cmdOutEn) begin
            frame = {frame[46:0], cmdOut};
            width++;
            @(negedge clk_fast);
        end
        compareValue(136'(width), 136'(sdCmdPkg::CmdFrameBits), "command frame length");
        compareValue(frame[47:8], data[47:8], "command payload");
        compareValue(frame[7:1], crc7Of(sdCmdPkg::respFrame_t'(data), 47, 8),
                     "command CRC7");
        compareValue(frame[0], 1'b1, "command end bit");
        // cmdDone toggles two samples after the last enabled bit
        compareValue(cmdDone, expCmdDone, "cmdDone toggled early");
        @(negedge clk_fast);
        expCmdDone = !expCmdDone;
        compareValue(cmdDone, expCmdDone, "cmdDone toggle");
        compareValue(respDone, expRespDone, "respDone toggled without a response");
    endtask

    task automatic sendResponse(input sdCmdPkg::respType_e kind, input logic abort);
        sdCmdPkg::respFrame_t frame;
        int frameBits;
        int crcMsb;
        int delay;
        int stopAfter;
        int flipPos;
        logic expErr;
        if (kind == sdCmdPkg::RespLong136) begin
            frameBits = sdCmdPkg::LongRespBits;
            crcMsb = frameBits - 1 - sdCmdPkg::LongRespCrcSkip;
        end else begin
            frameBits = sdCmdPkg::ShortRespBits;
            crcMsb = frameBits - 1;
        end
        for (int i = 0; i < sdCmdPkg::LongRespBits; i++) begin
            frame[i] = (i < frameBits) ? 1'($urandom_range(0, 1)) : 1'b0;
        end
        // Start bit and transmission bit are both 0 from the card
        frame[frameBits - 1] = 1'b0;
        frame[frameBits - 2] = 1'b0;
        frame[7:1] = crc7Of(frame, crcMsb, 8);
        frame[0] = 1'b1;
        // One flipped CRC or end bit makes the frame bad
        expErr = 1'b0;
        if ($urandom_range(0, 3) == 0) begin
            flipPos = $urandom_range(0, 7);
            frame[flipPos] = !frame[flipPos];
            expErr = 1'b1;
        end

        delay = TurnaroundCycles + $urandom_range(0, 17);
        stopAfter = abort ? $urandom_range(2, frameBits - 4) : frameBits;
        repeat (delay - 1) @(posedge clk_fast);
        for (int i = frameBits - 1; i >= frameBits - stopAfter; i--) begin
            @(posedge clk_fast);
            cmdIn <= frame[i];
        end
        if (!abort) begin
            @(posedge clk_fast);
            cmdIn <= 1'b1;
            @(negedge clk_fast);
            while (respDone == expRespDone) begin
                @(negedge clk_fast);
            end
            expRespDone = !expRespDone;
            compareValue(respData, frame, "response data");
            compareValue(respCrcErr, expErr, "response CRC error flag");
        end
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================

    initial begin
        sdCmdPkg::cmdFrame_t data;
        sdCmdPkg::respType_e kind;
        logic abort;
        reset = 1'b1;
        cmdTrigger = 1'b0;
        cmdData = '0;
        cmdRespType = sdCmdPkg::RespNone;
        cmdIn = 1'b1;
        expCmdDone = 1'b0;
        expRespDone = 1'b0;
        void'($urandom(32'h755d_86b2));

        repeat (3) @(posedge clk_fast);
        reset <= 1'b0;

        for (int n = 0; n < NumCommands; n++) begin
            data = {16'($urandom), 32'($urandom)};
            case ($urandom_range(0, 2))
                0: kind = sdCmdPkg::RespNone;
                1: kind = sdCmdPkg::RespShort48;
                default: kind = sdCmdPkg::RespLong136;
            endcase
            // An aborted response is cut short by the next trigger
            abort = (kind != sdCmdPkg::RespNone) && (n != NumCommands - 1) &&
                    ($urandom_range(0, 5) == 0);

            issueCommand(data, kind);
            checkCommandFrame(data);
            if (kind != sdCmdPkg::RespNone) begin
                sendResponse(kind, abort);
            end
            if (kind == sdCmdPkg::RespNone) begin
                repeat ($urandom_range(20, 40)) @(posedge clk_fast);
            end else if (!abort) begin
                repeat ($urandom_range(2, 10)) @(posedge clk_fast);
            end
        end

        repeat (20) @(negedge clk_fast);
        compareValue(cmdDone, expCmdDone, "cmdDone after the last command");
        compareValue(respDone, expRespDone, "respDone after the last command");
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/sdCmdController.sv
`timescale 1ns/1ns
`default_nettype none

module sdCmdController #(
    parameter int TurnaroundCycles = 3
) (
    input wire clk_fast,
    input wire reset,
    input wire cmdTrigger,
    input wire sdCmdPkg::cmdFrame_t cmdData,
    input wire sdCmdPkg::respType_e cmdRespType,
    input wire cmdIn,
    output wire cmdOut,
    output wire cmdOutEn,
    output wire cmdDone,
    output wire respDone,
    output wire sdCmdPkg::respFrame_t respData,
    output wire respCrcErr
);

    // Decoder to sender
    wire sendStart;
    wire sdCmdPkg::cmdFrame_t sendFrame;
    wire sendDone;

    // Decoder to receiver
    wire recvAbort;
    wire recvArm;
    wire sdCmdPkg::bitCount_t recvBits;
    wire sdCmdPkg::bitCount_t recvCrcSkip;

    cmdRequestDecoder i_cmdRequestDecoder (
        .clk_fast(clk_fast),
        .reset(reset),
        .cmdTrigger(cmdTrigger),
        .cmdData(cmdData),
        .cmdRespType(cmdRespType),
        .sendDone(sendDone),
        .sendStart(sendStart),
        .sendFrame(sendFrame),
        .recvAbort(recvAbort),
        .recvArm(recvArm),
        .recvBits(recvBits),
        .recvCrcSkip(recvCrcSkip),
        .cmdDone(cmdDone)
    );

    cmdLineSender i_cmdLineSender (
        .clk_fast(clk_fast),
        .reset(reset),
        .sendStart(sendStart),
        .sendFrame(sendFrame),
        .cmdOut(cmdOut),
        .cmdOutEn(cmdOutEn),
        .sendDone(sendDone)
    );

    respReceiver #(
        .TurnaroundCycles(TurnaroundCycles)
    ) i_respReceiver (
        .clk_fast(clk_fast),
        .reset(reset),
        .recvAbort(recvAbort),
        .recvArm(recvArm),
        .recvBits(recvBits),
        .recvCrcSkip(recvCrcSkip),
        .cmdIn(cmdIn),
        .cmdOutEn(cmdOutEn),
        .respDone(respDone),
        .respData(respData),
        .respCrcErr(respCrcErr)
    );

endmodule

`default_nettype wire

//--- src/respReceiver.sv
`timescale 1ns/1ns
`default_nettype none

module respReceiver #(
    parameter int TurnaroundCycles = 3
) (
    input wire clk_fast,
    input wire reset,
    input wire recvAbort,
    input wire recvArm,
    input wire sdCmdPkg::bitCount_t recvBits,
    input wire sdCmdPkg::bitCount_t recvCrcSkip,
    input wire cmdIn,
    input wire cmdOutEn,
    output logic respDone,
    output sdCmdPkg::respFrame_t respData,
    output logic respCrcErr
);

    localparam int QuietWidth = $clog2(TurnaroundCycles + 1);
    localparam int FrameMsb = sdCmdPkg::LongRespBits - 1;

    // CRC7 plus end bit close every response
    localparam sdCmdPkg::bitCount_t TrailBits = 8;

    // Position of the first bit after the start bit
    localparam sdCmdPkg::bitCount_t FirstDataPos = 2;

    typedef enum logic [2:0] {
        Idle,
        Turnaround,
        WaitStart,
        Capture,
        Check
    } state_e;

    state_e state;
    logic [QuietWidth-1:0] quietCnt;
    sdCmdPkg::bitCount_t bitPos;
    sdCmdPkg::respFrame_t shiftReg;
    sdCmdPkg::crc7_t crc;
    logic lineLive;
    logic startSeen;
    logic crcEnable;

    // ==========================================================
    // Turnaround, counted from the fall of cmdOutEn
    // ==========================================================

    assign lineLive = quietCnt == QuietWidth'(TurnaroundCycles);

    always_ff @(posedge clk_fast) begin
        if (reset) begin
            quietCnt <= '0;
        end else if (cmdOutEn) begin
            quietCnt <= '0;
        end else if (!lineLive) begin
            quietCnt <= quietCnt + 1'b1;
        end
    end

    // Start bit may already show in the first live cycle
    assign startSeen = !cmdIn &&
                       (state == WaitStart || (state == Turnaround && lineLive));

    // Skip the leading bits, stop before CRC and end bit
    assign crcEnable = state == Capture && bitPos > recvCrcSkip &&
                       bitPos <= recvBits - TrailBits;

    crc7Serial i_crc7Serial (
        .clk_fast(clk_fast),
        .reset(reset),
        .clear(recvAbort || recvArm),
        .enable(crcEnable),
        .dataBit(cmdIn),
        .crc(crc)
    );

    // ==========================================================
    // Receive FSM
    // ==========================================================

    always_ff @(posedge clk_fast) begin
        if (reset) begin
            state <= Idle;
            bitPos <= '0;
            respDone <= 1'b0;
            respCrcErr <= 1'b0;
        end else if (recvAbort) begin
            state <= Idle;
            respCrcErr <= 1'b0;
        end else if (recvArm) begin
            state <= Turnaround;
        end else if (startSeen) begin
            state <= Capture;
            bitPos <= FirstDataPos;
        end else begin
            case (state)
                Turnaround: begin
                    if (lineLive) begin
                        state <= WaitStart;
                    end
                end
                Capture: begin
                    if (bitPos == recvBits) begin
                        state <= Check;
                    end
                    bitPos <= bitPos + 1'b1;
                end
                Check: begin
                    // CRC in bits 7..1, end bit in bit 0
                    respCrcErr <= (crc != shiftReg[7:1]) || !shiftReg[0];
                    respDone <= !respDone;
                    state <= Idle;
                end
                default: ;
            endcase
        end
    end

    // Frame shifts in LSB side, the start bit ends up at recvBits-1
    always_ff @(posedge clk_fast) begin
        if (startSeen) begin
            shiftReg <= '0;
        end else if (state == Capture) begin
            shiftReg <= {shiftReg[FrameMsb-1:0], cmdIn};
        end
        if (state == Check) begin
            respData <= shiftReg;
        end
    end

    assert property (@(posedge clk_fast) disable iff (reset)
        state == Capture |-> !cmdOutEn)
        else $error("Response capture while the host drives CMD");

endmodule

`default_nettype wire

//--- src/cmdLineSender.sv
`timescale 1ns/1ns
`default_nettype none

module cmdLineSender (
    input wire clk_fast,
    input wire reset,
    input wire sendStart,
    input wire sdCmdPkg::cmdFrame_t sendFrame,
    output logic cmdOut,
    output logic cmdOutEn,
    output logic sendDone
);

    // Last index of the 40 payload bits and of the 7 CRC bits
    localparam sdCmdPkg::bitCount_t PayloadLast =
        sdCmdPkg::bitCount_t'(sdCmdPkg::CmdFrameBits - 9);
    localparam sdCmdPkg::bitCount_t CrcLast =
        sdCmdPkg::bitCount_t'($bits(sdCmdPkg::crc7_t) - 1);
    localparam int FrameMsb = sdCmdPkg::CmdFrameBits - 1;

    typedef enum logic [1:0] {
        Idle,
        Payload,
        Crc,
        End
    } state_e;

    state_e state;
    sdCmdPkg::cmdFrame_t shiftReg;
    sdCmdPkg::bitCount_t bitCnt;
    sdCmdPkg::crc7_t crc;

    crc7Serial i_crc7Serial (
        .clk_fast(clk_fast),
        .reset(reset),
        .clear(sendStart),
        .enable(state == Payload),
        .dataBit(shiftReg[FrameMsb]),
        .crc(crc)
    );

    // ==========================================================
    // Line drive
    // ==========================================================

    assign cmdOutEn = state != Idle;

    // End bit and idle level are both 1
    always_comb begin
        case (state)
            Payload: cmdOut = shiftReg[FrameMsb];
            Crc:     cmdOut = crc[bitCnt[2:0]];
            default: cmdOut = 1'b1;
        endcase
    end

    // ==========================================================
    // Frame sequencing
    // ==========================================================

    always_ff @(posedge clk_fast) begin
        if (reset) begin
            state <= Idle;
            bitCnt <= '0;
            sendDone <= 1'b0;
        end else begin
            sendDone <= 1'b0;
            if (sendStart) begin
                state <= Payload;
                bitCnt <= PayloadLast;
            end else begin
                case (state)
                    Payload: begin
                        if (bitCnt == '0) begin
                            state <= Crc;
                            bitCnt <= CrcLast;
                        end else begin
                            bitCnt <= bitCnt - 1'b1;
                        end
                    end
                    Crc: begin
                        // CRC goes out MSB first
                        if (bitCnt == '0) begin
                            state <= End;
                        end else begin
                            bitCnt <= bitCnt - 1'b1;
                        end
                    end
                    End: begin
                        state <= Idle;
                        sendDone <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_fast) begin
        if (sendStart) begin
            shiftReg <= sendFrame;
        end else if (state == Payload) begin
            shiftReg <= shiftReg << 1;
        end
    end

    // A restart keeps the line enabled, so the window check is dropped then
    assert property (@(posedge clk_fast) disable iff (reset || sendStart)
        $rose(cmdOutEn) |-> ##48 !cmdOutEn)
        else $error("cmdOutEn held beyond one command frame");

endmodule

`default_nettype wire

//--- src/cmdRequestDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module cmdRequestDecoder (
    input wire clk_fast,
    input wire reset,
    input wire cmdTrigger,
    input wire sdCmdPkg::cmdFrame_t cmdData,
    input wire sdCmdPkg::respType_e cmdRespType,
    input wire sendDone,
    output logic sendStart,
    output sdCmdPkg::cmdFrame_t sendFrame,
    output logic recvAbort,
    output logic recvArm,
    output sdCmdPkg::bitCount_t recvBits,
    output sdCmdPkg::bitCount_t recvCrcSkip,
    output logic cmdDone
);

    typedef enum logic {
        Idle,
        Sending
    } state_e;

    state_e state;
    logic trigSeen;
    logic trigEdge;
    sdCmdPkg::respType_e respType;

    // Toggle detect against the last sampled trigger level
    assign trigEdge = cmdTrigger != trigSeen;

    // A new command always restarts the receiver too
    assign recvAbort = sendStart;

    // Frame length and CRC skip for the latched response kind
    assign recvBits = (respType == sdCmdPkg::RespLong136) ?
                      sdCmdPkg::bitCount_t'(sdCmdPkg::LongRespBits) :
                      sdCmdPkg::bitCount_t'(sdCmdPkg::ShortRespBits);
    assign recvCrcSkip = (respType == sdCmdPkg::RespLong136) ?
                         sdCmdPkg::bitCount_t'(sdCmdPkg::LongRespCrcSkip) :
                         sdCmdPkg::bitCount_t'(0);

    always_ff @(posedge clk_fast) begin
        if (reset) begin
            state <= Idle;
            trigSeen <= 1'b0;
            sendStart <= 1'b0;
            recvArm <= 1'b0;
            cmdDone <= 1'b0;
            respType <= sdCmdPkg::RespNone;
        end else begin
            trigSeen <= cmdTrigger;
            sendStart <= trigEdge;
            recvArm <= 1'b0;
            if (trigEdge) begin
                state <= Sending;
                respType <= cmdRespType;
            end else if (state == Sending && sendDone && !sendStart) begin
                // sendDone next to a fresh start belongs to the aborted frame
                state <= Idle;
                cmdDone <= !cmdDone;
                recvArm <= respType != sdCmdPkg::RespNone;
            end
        end
    end

    // Command payload, held for the sender
    always_ff @(posedge clk_fast) begin
        if (trigEdge) begin
            sendFrame <= cmdData;
        end
    end

    assert property (@(posedge clk_fast) disable iff (reset)
        sendDone |-> state == Sending)
        else $error("sendDone with no command in flight");

endmodule

`default_nettype wire

//--- src/crc7Serial.sv
`timescale 1ns/1ns
`default_nettype none

// Bit-serial CRC7, polynomial x^7 + x^3 + 1
module crc7Serial (
    input wire clk_fast,
    input wire reset,
    input wire clear,
    input wire enable,
    input wire dataBit,
    output sdCmdPkg::crc7_t crc
);

    logic feedback;

    // MSB of the remainder meets the incoming bit
    assign feedback = dataBit ^ crc[6];

    always_ff @(posedge clk_fast) begin
        if (reset) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (enable) begin
            // Shift left, feedback enters at x^0 and is folded into x^3
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end
    end

endmodule

`default_nettype wire

//--- src/sdCmdPkg.sv
`default_nettype none

package sdCmdPkg;

    // ==========================================================
    // Frame lengths fixed by the SD protocol
    // ==========================================================

    // Command frame on the CMD line
    localparam int CmdFrameBits = 48;

    // R1/R3/R6/R7 style response
    localparam int ShortRespBits = 48;

    // R2 response (CID/CSD)
    localparam int LongRespBits = 136;

    // Start, transmission and reserved bits of R2 sit outside the CRC
    localparam int LongRespCrcSkip = 8;

    // ==========================================================
    // Types
    // ==========================================================

    typedef enum logic [1:0] {
        RespNone    = 2'b00,
        RespShort48 = 2'b01,
        RespLong136 = 2'b10
    } respType_e;

    typedef logic [CmdFrameBits-1:0] cmdFrame_t;

    // Right-aligned, a short response leaves the upper bits zero
    typedef logic [LongRespBits-1:0] respFrame_t;

    typedef logic [6:0] crc7_t;

    // Wide enough for the 136 bit frame
    typedef logic [7:0] bitCount_t;

endpackage

`default_nettype wire
